//--- hw/axi_req_issue.sv
// Turns the command slot into AXI4-Lite AW+W or AR transfers.
// cmd_* inputs must hold until cmd_done_o, which fires in the last handshake cycle.
// AW and W may complete in either order. Valids come from registers only.

`timescale 1ns/10ps

module axi_req_issue (
    input  logic                clk_i,
    input  logic                rst_i,

    // command slot
    input  logic                cmd_valid_i,
    input  obi2axi_pkg::addr_t  cmd_addr_i,
    input  logic                cmd_we_i,
    input  obi2axi_pkg::data_t  cmd_wdata_i,
    input  obi2axi_pkg::strb_t  cmd_be_i,
    output logic                cmd_done_o,

    // AXI4-Lite write address and data
    output logic                awvalid_o,
    output obi2axi_pkg::addr_t  awaddr_o,
    input  logic                awready_i,
    output logic                wvalid_o,
    output obi2axi_pkg::data_t  wdata_o,
    output obi2axi_pkg::strb_t  wstrb_o,
    input  logic                wready_i,

    // AXI4-Lite read address
    output logic                arvalid_o,
    output obi2axi_pkg::addr_t  araddr_o,
    input  logic                arready_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DONE
    } state_e;

    state_e state_q, state_d;

    logic aw_ok_q;  // AW already handshaken
    logic w_ok_q;   // W already handshaken
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic all_done;

    assign awvalid_o = (state_q == ST_ISSUE) && cmd_we_i && !aw_ok_q;
    assign wvalid_o  = (state_q == ST_ISSUE) && cmd_we_i && !w_ok_q;
    assign arvalid_o = (state_q == ST_ISSUE) && !cmd_we_i;

    assign awaddr_o = cmd_addr_i;
    assign wdata_o  = cmd_wdata_i;
    assign wstrb_o  = cmd_be_i;   // OBI byte enables map straight to strobes
    assign araddr_o = cmd_addr_i;

    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign ar_hs = arvalid_o && arready_i;

    // counts handshakes from earlier cycles and this one
    assign all_done = cmd_we_i ? ((aw_ok_q || aw_hs) && (w_ok_q || w_hs)) : ar_hs;

    assign cmd_done_o = (state_q == ST_ISSUE) && all_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_valid_i) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                if (all_done) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                // slot may already hold the next command
                state_d = cmd_valid_i ? ST_ISSUE : ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // handshake flags, cleared once the command retires
    always_ff @(posedge clk_i) begin
        if (rst_i || state_q == ST_DONE) begin
            aw_ok_q <= 1'b0;
            w_ok_q  <= 1'b0;
        end else begin
            if (aw_hs) aw_ok_q <= 1'b1;
            if (w_hs)  w_ok_q  <= 1'b1;
        end
    end

    aw_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o)
    );

    ar_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o)
    );

    w_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable({wdata_o, wstrb_o})
    );

endmodule

//--- hw/obi2axi_bridge.sv
// OBI peripheral port to AXI4-Lite manager bridge, top level.
// Up to ORD_DEPTH transactions outstanding, responses returned in request order.
// No AXI IDs, prot or user signals. All AXI transfers are single beat.

`timescale 1ns/10ps

module obi2axi_bridge (
    input  logic                clk_i,
    input  logic                rst_i,

    // OBI request
    input  logic                a_req_i,
    input  obi2axi_pkg::addr_t  a_addr_i,
    input  logic                a_we_i,
    input  obi2axi_pkg::data_t  a_wdata_i,
    input  obi2axi_pkg::strb_t  a_be_i,
    input  obi2axi_pkg::id_t    a_aid_i,
    output logic                a_gnt_o,

    // OBI response
    output logic                r_valid_o,
    output obi2axi_pkg::data_t  r_rdata_o,
    output logic                r_err_o,
    output obi2axi_pkg::id_t    r_rid_o,
    input  logic                r_ready_i,

    // AXI4-Lite manager
    output logic                awvalid_o,
    output obi2axi_pkg::addr_t  awaddr_o,
    input  logic                awready_i,
    output logic                wvalid_o,
    output obi2axi_pkg::data_t  wdata_o,
    output obi2axi_pkg::strb_t  wstrb_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    input  obi2axi_pkg::resp_t  bresp_i,
    output logic                bready_o,
    output logic                arvalid_o,
    output obi2axi_pkg::addr_t  araddr_o,
    input  logic                arready_i,
    input  logic                rvalid_i,
    input  obi2axi_pkg::data_t  rdata_i,
    input  obi2axi_pkg::resp_t  rresp_i,
    output logic                rready_o
);

    import obi2axi_pkg::*;

    // command slot
    logic  cmd_valid;
    addr_t cmd_addr;
    logic  cmd_we;
    data_t cmd_wdata;
    strb_t cmd_be;
    logic  cmd_done;

    // order queue
    logic  ord_push;
    logic  ord_we;
    id_t   ord_id;
    logic  ord_ready;

    obi_req_accept u_accept (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .a_req_i     (a_req_i),
        .a_addr_i    (a_addr_i),
        .a_we_i      (a_we_i),
        .a_wdata_i   (a_wdata_i),
        .a_be_i      (a_be_i),
        .a_aid_i     (a_aid_i),
        .a_gnt_o     (a_gnt_o),
        .cmd_valid_o (cmd_valid),
        .cmd_addr_o  (cmd_addr),
        .cmd_we_o    (cmd_we),
        .cmd_wdata_o (cmd_wdata),
        .cmd_be_o    (cmd_be),
        .cmd_done_i  (cmd_done),
        .ord_push_o  (ord_push),
        .ord_we_o    (ord_we),
        .ord_id_o    (ord_id),
        .ord_ready_i (ord_ready)
    );

    axi_req_issue u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid),
        .cmd_addr_i  (cmd_addr),
        .cmd_we_i    (cmd_we),
        .cmd_wdata_i (cmd_wdata),
        .cmd_be_i    (cmd_be),
        .cmd_done_o  (cmd_done),
        .awvalid_o   (awvalid_o),
        .awaddr_o    (awaddr_o),
        .awready_i   (awready_i),
        .wvalid_o    (wvalid_o),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o),
        .wready_i    (wready_i),
        .arvalid_o   (arvalid_o),
        .araddr_o    (araddr_o),
        .arready_i   (arready_i)
    );

    obi_rsp_return u_return (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ord_push_i  (ord_push),
        .ord_we_i    (ord_we),
        .ord_id_i    (ord_id),
        .ord_ready_o (ord_ready),
        .bvalid_i    (bvalid_i),
        .bresp_i     (bresp_i),
        .bready_o    (bready_o),
        .rvalid_i    (rvalid_i),
        .rdata_i     (rdata_i),
        .rresp_i     (rresp_i),
        .rready_o    (rready_o),
        .r_valid_o   (r_valid_o),
        .r_rdata_o   (r_rdata_o),
        .r_err_o     (r_err_o),
        .r_rid_o     (r_rid_o),
        .r_ready_i   (r_ready_i)
    );

endmodule

//--- hw/obi2axi_pkg.sv
// Shared widths, vector types and AXI response codes for the OBI to AXI4-Lite bridge.
// ORD_DEPTH must be a power of two because the order queue pointers wrap freely.
// Only OKAY and SLVERR are named here. Any non-OKAY code counts as an error.

package obi2axi_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // outstanding limit, one order queue entry per transaction
    localparam int ORD_DEPTH = 4;
    localparam int ORD_PTR_W = $clog2(ORD_DEPTH);

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // one data word
    typedef logic [DATA_W-1:0] data_t;

    // byte enables and write strobes
    typedef logic [STRB_W-1:0] strb_t;

    // OBI aid / rid
    typedef logic [ID_W-1:0] id_t;

    // AXI bresp / rresp
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- hw/obi_req_accept.sv
// OBI request side of the bridge. Holds one command at a time.
// a_gnt_o is combinational from a_req_i, cmd_done_i and ord_ready_i.
// The request fields must stay stable while a_req_i waits for the grant.

`timescale 1ns/10ps

module obi_req_accept (
    input  logic                clk_i,
    input  logic                rst_i,

    // OBI request channel
    input  logic                a_req_i,
    input  obi2axi_pkg::addr_t  a_addr_i,
    input  logic                a_we_i,
    input  obi2axi_pkg::data_t  a_wdata_i,
    input  obi2axi_pkg::strb_t  a_be_i,
    input  obi2axi_pkg::id_t    a_aid_i,
    output logic                a_gnt_o,

    // command slot towards the AXI issue logic
    output logic                cmd_valid_o,
    output obi2axi_pkg::addr_t  cmd_addr_o,
    output logic                cmd_we_o,
    output obi2axi_pkg::data_t  cmd_wdata_o,
    output obi2axi_pkg::strb_t  cmd_be_o,
    input  logic                cmd_done_i,

    // order queue push
    output logic                ord_push_o,
    output logic                ord_we_o,
    output obi2axi_pkg::id_t    ord_id_o,
    input  logic                ord_ready_i
);

    import obi2axi_pkg::*;

    logic  cmd_valid_q;
    addr_t cmd_addr_q;
    logic  cmd_we_q;
    data_t cmd_wdata_q;
    strb_t cmd_be_q;
    logic  slot_free;

    // slot can be refilled in the same cycle it retires
    assign slot_free = !cmd_valid_q || cmd_done_i;
    assign a_gnt_o   = a_req_i && slot_free && ord_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_q <= 1'b0;
        end else if (a_gnt_o) begin
            cmd_valid_q <= 1'b1;
        end else if (cmd_done_i) begin
            cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_gnt_o) begin
            cmd_addr_q  <= a_addr_i;
            cmd_we_q    <= a_we_i;
            cmd_wdata_q <= a_wdata_i;
            cmd_be_q    <= a_be_i;
        end
    end

    assign cmd_valid_o = cmd_valid_q;
    assign cmd_addr_o  = cmd_addr_q;
    assign cmd_we_o    = cmd_we_q;
    assign cmd_wdata_o = cmd_wdata_q;
    assign cmd_be_o    = cmd_be_q;

    // order entry goes in together with the grant
    assign ord_push_o = a_gnt_o;
    assign ord_we_o   = a_we_i;
    assign ord_id_o   = a_aid_i;

    // requester holds its fields until the grant
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        a_req_i && !a_gnt_o |=> $stable({a_addr_i, a_we_i, a_wdata_i, a_be_i, a_aid_i})
    );

    // the issue side only retires a loaded slot
    done_needs_slot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cmd_done_i |-> cmd_valid_q
    );

endmodule

//--- hw/obi_rsp_return.sv
// Order queue plus OBI response register.
// Only the B or R channel named by the oldest entry is accepted, so responses
// leave in request order. Write responses carry zero rdata.

`timescale 1ns/10ps

module obi_rsp_return (
    input  logic                clk_i,
    input  logic                rst_i,

    // order queue push from the request side
    input  logic                ord_push_i,
    input  logic                ord_we_i,
    input  obi2axi_pkg::id_t    ord_id_i,
    output logic                ord_ready_o,

    // AXI4-Lite responses
    input  logic                bvalid_i,
    input  obi2axi_pkg::resp_t  bresp_i,
    output logic                bready_o,
    input  logic                rvalid_i,
    input  obi2axi_pkg::data_t  rdata_i,
    input  obi2axi_pkg::resp_t  rresp_i,
    output logic                rready_o,

    // OBI response channel
    output logic                r_valid_o,
    output obi2axi_pkg::data_t  r_rdata_o,
    output logic                r_err_o,
    output obi2axi_pkg::id_t    r_rid_o,
    input  logic                r_ready_i
);

    import obi2axi_pkg::*;

    logic                 ord_we_q [ORD_DEPTH];
    id_t                  ord_id_q [ORD_DEPTH];
    logic [ORD_PTR_W-1:0] wr_ptr_q;
    logic [ORD_PTR_W-1:0] rd_ptr_q;
    logic [ORD_PTR_W:0]   cnt_q;
    logic                 empty;
    logic                 head_we;
    logic                 rsp_free;
    logic                 b_hs;
    logic                 r_hs;
    logic                 pop;
    logic                 r_valid_q;
    data_t                r_rdata_q;
    logic                 r_err_q;
    id_t                  r_rid_q;

    assign empty       = (cnt_q == '0);
    assign ord_ready_o = (cnt_q != ORD_DEPTH[ORD_PTR_W:0]);
    assign head_we     = ord_we_q[rd_ptr_q];

    // register empty or draining this cycle
    assign rsp_free = !r_valid_q || r_ready_i;
    assign bready_o = !empty && head_we && rsp_free;
    assign rready_o = !empty && !head_we && rsp_free;

    assign b_hs = bvalid_i && bready_o;
    assign r_hs = rvalid_i && rready_o;
    assign pop  = b_hs || r_hs;

    always_ff @(posedge clk_i) begin
        if (ord_push_i) begin
            ord_we_q[wr_ptr_q] <= ord_we_i;
            ord_id_q[wr_ptr_q] <= ord_id_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (ord_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)        rd_ptr_q <= rd_ptr_q + 1'b1;
            cnt_q <= cnt_q + (ORD_PTR_W+1)'(ord_push_i) - (ORD_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            r_valid_q <= 1'b0;
        end else if (pop) begin
            r_valid_q <= 1'b1;
        end else if (r_ready_i) begin
            r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            r_rdata_q <= head_we ? '0 : rdata_i;
            r_err_q   <= (head_we ? bresp_i : rresp_i) != RESP_OKAY;  // SLVERR and DECERR
            r_rid_q   <= ord_id_q[rd_ptr_q];
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_rdata_o = r_rdata_q;
    assign r_err_o   = r_err_q;
    assign r_rid_o   = r_rid_q;

    // subordinate answers only while something is outstanding
    no_rsp_when_empty: assert property (
        @(posedge clk_i) disable iff (rst_i)
        bvalid_i || rvalid_i |-> !empty
    );

endmodule

//--- obi2axi_bridge.f
hw/obi2axi_pkg.sv
hw/obi_req_accept.sv
hw/axi_req_issue.sv
hw/obi_rsp_return.sv
hw/obi2axi_bridge.sv
verif/tb_clk_gen.sv
verif/tb_obi2axi_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it.
# The run passes only if the log holds the pass line of the testbench.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_obi2axi_bridge \
    -f obi2axi_bridge.f \
    -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -qx "SIMULATION PASSED" "$LOG"; then
    echo "run_sim: pass"
else
    echo "run_sim: fail, see $LOG"
    exit 1
fi

//--- verif/tb_clk_gen.sv
// Testbench clock, 100 ns period, first rising edge at 50 ns.
// Reset is high from time 0 for two rising edges and drops on a falling edge.

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_NS = 50;

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;   // away from the sampling edge
    end

    always #HALF_NS clk_o = ~clk_o;

endmodule

//--- verif/tb_obi2axi_bridge.sv
// Testbench for the OBI to AXI4-Lite bridge with a random latency AXI4-Lite memory.
// Addresses at or above ERR_LIMIT answer SLVERR, memory is sparse and word addressed.
// Inputs change on the falling edge, handshakes are sampled on the rising edge.
// The run stops at the first error.

`timescale 1ns/10ps

module tb_obi2axi_bridge;

    import obi2axi_pkg::*;

    localparam int    SEED       = 52239;
    localparam addr_t ERR_LIMIT  = 32'h0001_0000;
    localparam int    GNT_WAIT   = 200;    // cycles
    localparam int    DRAIN_WAIT = 2000;
    localparam int    STALL_WAIT = 60;
    localparam int    RST_WAIT   = 10;
    localparam int    N_MIX      = 80;

    logic  clk;
    logic  rst;
    logic  a_req = 1'b0;
    addr_t a_addr = '0;
    logic  a_we = 1'b0;
    data_t a_wdata = '0;
    strb_t a_be = '0;
    id_t   a_aid = '0;
    logic  a_gnt;
    logic  r_valid;
    data_t r_rdata;
    logic  r_err;
    id_t   r_rid;
    logic  r_ready = 1'b1;
    logic  awvalid;
    addr_t awaddr;
    logic  awready = 1'b0;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  wready = 1'b0;
    logic  bvalid = 1'b0;
    resp_t bresp = RESP_OKAY;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  arready = 1'b0;
    logic  rvalid = 1'b0;
    data_t rdata = '0;
    resp_t rresp = RESP_OKAY;
    logic  rready;

    data_t shadow [addr_t];     // reference view, updated at grant
    data_t axi_mem [addr_t];    // responder storage
    addr_t aw_q [$];
    data_t wd_q [$];
    strb_t ws_q [$];
    resp_t b_pend [$];
    data_t rd_pend [$];
    resp_t rr_pend [$];
    logic  b_taken = 1'b0;
    logic  r_taken = 1'b0;
    addr_t wr_word;
    data_t wr_old;
    string exp_name [$];
    data_t exp_rdata [$];
    logic  exp_err [$];
    id_t   exp_id [$];
    int    req_count = 0;
    int    rsp_count = 0;
    id_t   next_aid = '0;
    logic  held = 1'b0;
    logic [DATA_W+ID_W:0] held_rsp;

    tb_clk_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    obi2axi_bridge dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .a_req_i   (a_req),
        .a_addr_i  (a_addr),
        .a_we_i    (a_we),
        .a_wdata_i (a_wdata),
        .a_be_i    (a_be),
        .a_aid_i   (a_aid),
        .a_gnt_o   (a_gnt),
        .r_valid_o (r_valid),
        .r_rdata_o (r_rdata),
        .r_err_o   (r_err),
        .r_rid_o   (r_rid),
        .r_ready_i (r_ready),
        .awvalid_o (awvalid),
        .awaddr_o  (awaddr),
        .awready_i (awready),
        .wvalid_o  (wvalid),
        .wdata_o   (wdata),
        .wstrb_o   (wstrb),
        .wready_i  (wready),
        .bvalid_i  (bvalid),
        .bresp_i   (bresp),
        .bready_o  (bready),
        .arvalid_o (arvalid),
        .araddr_o  (araddr),
        .arready_i (arready),
        .rvalid_i  (rvalid),
        .rdata_i   (rdata),
        .rresp_i   (rresp),
        .rready_o  (rready)
    );

    function automatic addr_t word_of(input addr_t addr);
        return {addr[ADDR_W-1:2], 2'b00};
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wdat, input strb_t be);
        data_t merged;
        merged = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (be[i]) merged[8*i +: 8] = wdat[8*i +: 8];
        end
        return merged;
    endfunction

    // expected {err, rdata} of one access, writes update the shadow
    function automatic logic [DATA_W:0] ref_access(input logic we, input addr_t addr,
                                                   input data_t wdat, input strb_t be);
        data_t old;
        if (addr >= ERR_LIMIT) begin
            return {1'b1, {DATA_W{1'b0}}};
        end
        old = shadow.exists(word_of(addr)) ? shadow[word_of(addr)] : '0;
        if (!we) begin
            return {1'b0, old};
        end
        shadow[word_of(addr)] = merge_bytes(old, wdat, be);
        return {1'b0, {DATA_W{1'b0}}};
    endfunction

    function automatic addr_t rand_addr();
        if ($urandom_range(0, 7) == 0) begin
            return ERR_LIMIT + 4 * $urandom_range(0, 3);
        end
        return 32'h0000_1000 + 4 * $urandom_range(0, 15);
    endfunction

    task automatic stop_on_error(input string what);
        $display("ERROR: %s at %0t", what, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // drives one request from a falling edge, returns on the falling edge after it
    task automatic obi_request(input string name, input logic we, input addr_t addr,
                               input data_t wdat, input strb_t be, input int max_wait,
                               output logic granted);
        logic [DATA_W:0] expected;
        int              waited;
        a_req   = 1'b1;
        a_we    = we;
        a_addr  = addr;
        a_wdata = wdat;
        a_be    = be;
        a_aid   = next_aid;
        waited  = 0;
        granted = 1'b0;
        while (!granted && waited < max_wait) begin
            @(posedge clk);
            granted = a_gnt;
            waited++;
        end
        if (granted) begin
            expected = ref_access(we, addr, wdat, be);
            exp_name.push_back(name);
            exp_err.push_back(expected[DATA_W]);
            exp_rdata.push_back(expected[DATA_W-1:0]);
            exp_id.push_back(next_aid);
            next_aid++;
            req_count++;
        end
        @(negedge clk);
        a_req = 1'b0;
    endtask

    task automatic do_access(input string name, input logic we, input addr_t addr,
                             input data_t wdat, input strb_t be);
        logic granted;
        obi_request(name, we, addr, wdat, be, GNT_WAIT, granted);
        if (!granted) begin
            stop_on_error({name, ": request was never granted"});
        end
    endtask

    task automatic wait_for_responses(input string name);
        int waited;
        waited = 0;
        while (rsp_count != req_count) begin
            if (waited >= DRAIN_WAIT) begin
                stop_on_error({name, ": responses still missing after timeout"});
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // AXI4-Lite memory, handshake side
    always @(posedge clk) begin
        if (awvalid && awready) aw_q.push_back(awaddr);
        if (wvalid && wready) begin
            wd_q.push_back(wdata);
            ws_q.push_back(wstrb);
        end
        if (aw_q.size() > 0 && wd_q.size() > 0) begin
            wr_word = word_of(aw_q.pop_front());
            if (wr_word >= ERR_LIMIT) begin
                void'(wd_q.pop_front());
                void'(ws_q.pop_front());
                b_pend.push_back(RESP_SLVERR);   // write dropped
            end else begin
                wr_old = axi_mem.exists(wr_word) ? axi_mem[wr_word] : '0;
                axi_mem[wr_word] = merge_bytes(wr_old, wd_q.pop_front(), ws_q.pop_front());
                b_pend.push_back(RESP_OKAY);
            end
        end
        if (arvalid && arready) begin
            if (araddr >= ERR_LIMIT) begin
                rd_pend.push_back('0);
                rr_pend.push_back(RESP_SLVERR);
            end else begin
                rd_pend.push_back(axi_mem.exists(word_of(araddr)) ?
                                  axi_mem[word_of(araddr)] : '0);
                rr_pend.push_back(RESP_OKAY);
            end
        end
        if (bvalid && bready) b_taken = 1'b1;
        if (rvalid && rready) r_taken = 1'b1;
    end

    // AXI4-Lite memory, drive side with random readies and delays
    always @(negedge clk) begin
        awready = ($urandom_range(0, 3) != 0);
        wready  = ($urandom_range(0, 3) != 0);
        arready = ($urandom_range(0, 3) != 0);
        if (b_taken) begin
            bvalid  = 1'b0;
            b_taken = 1'b0;
        end
        if (r_taken) begin
            rvalid  = 1'b0;
            r_taken = 1'b0;
        end
        // B and R start independently, so either may come first
        if (!bvalid && b_pend.size() > 0 && $urandom_range(0, 2) == 0) begin
            bvalid = 1'b1;
            bresp  = b_pend.pop_front();
        end
        if (!rvalid && rd_pend.size() > 0 && $urandom_range(0, 2) == 0) begin
            rvalid = 1'b1;
            rdata  = rd_pend.pop_front();
            rresp  = rr_pend.pop_front();
        end
    end

    // OBI responses against the expected entries, in grant order
    always @(posedge clk) begin
        if (!rst) begin
            if (held) begin
                check_equal("stalled r_valid", 1, r_valid);
                check_equal("stalled response fields", held_rsp, {r_err, r_rid, r_rdata});
            end
            held     = r_valid && !r_ready;
            held_rsp = {r_err, r_rid, r_rdata};
            if (r_valid && r_ready) begin
                if (exp_rdata.size() == 0) begin
                    stop_on_error("OBI response with no request outstanding");
                end else begin
                    check_equal({exp_name[0], " rdata"}, exp_rdata.pop_front(), r_rdata);
                    check_equal({exp_name[0], " err"}, exp_err.pop_front(), r_err);
                    check_equal({exp_name[0], " rid"}, exp_id.pop_front(), r_rid);
                    void'(exp_name.pop_front());
                    rsp_count++;
                end
            end
        end
    end

    initial begin
        addr_t addr_list [$];
        addr_t addr;
        int    waited;
        int    stall_grants;
        logic  granted;

        void'($urandom(SEED));
        waited = 0;
        while (rst !== 1'b0) begin
            if (waited >= RST_WAIT) begin
                stop_on_error("reset never released");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        @(negedge clk);

        repeat (4) begin
            @(posedge clk);
            check_equal("idle after reset", 0,
                        {a_gnt, r_valid, awvalid, wvalid, arvalid, bready, rready});
        end
        @(negedge clk);
        do_access("unwritten read", 1'b0, 32'h0000_0800, '0, '0);
        wait_for_responses("unwritten read");

        // repeated addresses merge several strobed writes
        for (int i = 0; i < 16; i++) begin
            addr = 32'h0000_1000 + 4 * $urandom_range(0, 7);
            addr_list.push_back(addr);
            do_access("write merge", 1'b1, addr, $urandom(), strb_t'($urandom_range(0, 15)));
        end
        foreach (addr_list[i]) begin
            do_access("read back", 1'b0, addr_list[i], '0, '0);
        end
        wait_for_responses("read back");

        // error write would alias a written word if the limit bit got lost
        do_access("error write", 1'b1, ERR_LIMIT + addr_list[0], 32'hdead_beef, 4'hf);
        do_access("error read", 1'b0, ERR_LIMIT + addr_list[0], '0, '0);
        do_access("error read", 1'b0, 32'hffff_fffc, '0, '0);
        do_access("read after error", 1'b0, addr_list[0], '0, '0);
        wait_for_responses("error limit");

        for (int i = 0; i < N_MIX; i++) begin
            do_access("random mix", 1'($urandom_range(0, 1)), rand_addr(), $urandom(),
                      strb_t'($urandom_range(0, 15)));
        end
        wait_for_responses("random mix");

        // queue plus response register fill up, then grants stop
        r_ready      = 1'b0;
        stall_grants = 0;
        granted      = 1'b1;
        while (granted && stall_grants <= ORD_DEPTH + 1) begin
            obi_request("stalled", 1'($urandom_range(0, 1)), rand_addr(), $urandom(),
                        strb_t'($urandom_range(0, 15)), STALL_WAIT, granted);
            if (granted) stall_grants++;
        end
        check_equal("stall grant count", ORD_DEPTH + 1, stall_grants);
        repeat (10) @(negedge clk);
        r_ready = 1'b1;
        wait_for_responses("stalled");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
